//--- common/sdramCmdPkg.sv
package sdramCmdPkg;

    ////////////////////////////////////////////////////////////
    // pin side widths and address constants
    ////////////////////////////////////////////////////////////

    localparam int opWidth = 5;                 // cke, cs, ras, cas, we
    localparam int rowAddrWidth = 13;           // A12..A0, 8192 rows
    localparam int bankAddrWidth = 2;           // BA1..BA0, 4 banks
    localparam int prechargeAllBit = 10;        // A10 high on precharge selects all banks

    ////////////////////////////////////////////////////////////
    // command opcodes, bit order cke cs ras cas we
    ////////////////////////////////////////////////////////////

    typedef enum logic [opWidth-1:0] {
        opPowerUp   = 5'b00000,                 // cke and cs low while supply settles
        opDeselect  = 5'b11111,                 // chip not selected
        opNop       = 5'b10111,                 // selected, no operation
        opPrecharge = 5'b10010,                 // A10 picks one bank or all
        opRefresh   = 5'b10001,                 // auto refresh, banks must be idle
        opModeSet   = 5'b10000                  // mode register load from address pins
    } sdramOp_t;

    // registered pin bus, op sits in the top bits
    typedef struct packed {
        sdramOp_t                 op;           // control pins
        logic [rowAddrWidth-1:0]  addr;         // row / mode address
        logic [bankAddrWidth-1:0] ba;           // bank select
    } sdramBus_t;

    // value the pins hold through reset and the power-up wait
    localparam sdramBus_t busIdle = '{
        op:   opPowerUp,
        addr: '0,
        ba:   '0
    };

endpackage

//--- common/sdramSeqPkg.sv
package sdramSeqPkg;

    ////////////////////////////////////////////////////////////
    // controller side definitions
    ////////////////////////////////////////////////////////////

    localparam int timerWidth = 16;             // both timers and their load values

    // init runs top to bottom once, the refresh states loop forever
    typedef enum logic [3:0] {
        stInit,                                 // load power-up wait
        stPowerWait,                            // cke low until timer expires
        stFirstNop,                             // first command with cke high
        stPrechargeInit,                        // precharge all before init refreshes
        stInitRefresh,                          // one of the counted init refreshes
        stInitGap,                              // nops after each init refresh
        stModeSet,                              // load mode register
        stModeGap,                              // nops after mode set
        stRefreshIdle,                          // wait for refresh interval
        stRefreshPrecharge,                     // precharge all ahead of refresh
        stRefreshNop,                           // single nop after precharge
        stRefresh,                              // periodic auto refresh
        stRefreshGap                            // nops after periodic refresh
    } seqState_t;

endpackage

//--- run.sh
#!/usr/bin/env bash
# build and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tbSdramController -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/simv > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi

# the log decides pass or fail
if grep -q "Simulation finished: FAIL" "$logFile"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$logFile"; then
    echo "no final result in $logFile"
    exit 1
fi
exit 0

//--- sequencer/sdramSequencer.sv
`timescale 1ns/1ps

module sdramSequencer #(
    parameter logic [3:0] initRefreshCount = 4'd8,      // refreshes during init
    parameter logic [3:0] refreshGap = 4'd3,            // nops after refresh and mode set
    parameter logic [sdramSeqPkg::timerWidth-1:0] refreshInterval = 16'd375,
    parameter logic [sdramSeqPkg::timerWidth-1:0] powerUpCycles = 16'd5000,
    parameter logic [sdramCmdPkg::rowAddrWidth-1:0] modeRegValue = 13'h220
) (
    input  logic                                Clock,
    input  logic                                Reset_L,
    input  logic                                timerDone,      // gap timer at zero
    input  logic                                refreshDone,    // refresh timer at zero
    output logic                                timerLoad,
    output logic [sdramSeqPkg::timerWidth-1:0]  timerValue,
    output logic                                refreshLoad,
    output logic [sdramSeqPkg::timerWidth-1:0]  refreshValue,
    output sdramCmdPkg::sdramBus_t              sdramBus,       // registered pins
    output logic                                cpuReset_L      // low until init done
);

    import sdramCmdPkg::*;
    import sdramSeqPkg::*;

    // timer stays in a gap state for load+1 cycles, so load one less
    localparam logic [timerWidth-1:0] gapLoad = timerWidth'(refreshGap - 4'd1);

    seqState_t  state;
    seqState_t  stateNext;
    logic [3:0] initCount;                      // init refreshes issued so far
    logic [3:0] countNext;
    sdramBus_t  busNext;                        // command for the current state
    logic       cpuResetNext;

    ////////////////////////////////////////////////////////////
    // state, counter and pins, all on one edge
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            state <= stInit;
            initCount <= '0;
            sdramBus <= busIdle;                // cke and cs low
            cpuReset_L <= 1'b0;                 // hold cpu in reset
        end else begin
            state <= stateNext;
            initCount <= countNext;
            sdramBus <= busNext;                // command lags state by one cycle
            cpuReset_L <= cpuResetNext;
        end
    end

    ////////////////////////////////////////////////////////////
    // next state, command and timer loads
    ////////////////////////////////////////////////////////////
    always_comb begin
        stateNext = state;                      // stay unless told otherwise
        countNext = initCount;
        cpuResetNext = cpuReset_L;              // only ever rises once per reset
        busNext.op = opNop;                     // nop is the common filler
        busNext.addr = '0;
        busNext.ba = '0;
        timerLoad = 1'b0;
        timerValue = '0;
        refreshLoad = 1'b0;
        refreshValue = '0;

        case (state)
            stInit: begin
                busNext.op = opPowerUp;
                timerLoad = 1'b1;               // start power-up wait
                timerValue = powerUpCycles;
                countNext = '0;
                cpuResetNext = 1'b0;
                stateNext = stPowerWait;
            end

            stPowerWait: begin
                busNext.op = opPowerUp;         // keep cke low
                if (timerDone) begin
                    stateNext = stFirstNop;
                end
            end

            stFirstNop: begin
                busNext.op = opNop;             // cke goes high here
                stateNext = stPrechargeInit;
            end

            stPrechargeInit: begin
                busNext.op = opPrecharge;
                busNext.addr[prechargeAllBit] = 1'b1;   // all banks
                countNext = '0;                 // fresh count for the loop
                stateNext = stInitRefresh;
            end

            stInitRefresh: begin
                busNext.op = opRefresh;
                timerLoad = 1'b1;               // time the nop gap
                timerValue = gapLoad;
                countNext = initCount + 4'd1;
                stateNext = stInitGap;
            end

            stInitGap: begin
                busNext.op = opNop;
                if (timerDone) begin
                    if (initCount == initRefreshCount) begin
                        stateNext = stModeSet;  // loop done
                    end else begin
                        stateNext = stInitRefresh;
                    end
                end
            end

            stModeSet: begin
                busNext.op = opModeSet;
                busNext.addr = modeRegValue;    // cas latency and burst length
                busNext.ba = '0;                // base mode register
                timerLoad = 1'b1;
                timerValue = gapLoad;
                stateNext = stModeGap;
            end

            stModeGap: begin
                busNext.op = opNop;
                if (timerDone) begin
                    refreshLoad = 1'b1;         // first refresh interval
                    refreshValue = refreshInterval;
                    cpuResetNext = 1'b1;        // init finished, release cpu
                    stateNext = stRefreshIdle;
                end
            end

            stRefreshIdle: begin
                busNext.op = opNop;
                if (refreshDone) begin
                    stateNext = stRefreshPrecharge;
                end
            end

            stRefreshPrecharge: begin
                busNext.op = opPrecharge;
                busNext.addr[prechargeAllBit] = 1'b1;
                stateNext = stRefreshNop;
            end

            stRefreshNop: begin
                busNext.op = opNop;             // exactly one
                stateNext = stRefresh;
            end

            stRefresh: begin
                busNext.op = opRefresh;
                timerLoad = 1'b1;
                timerValue = gapLoad;
                stateNext = stRefreshGap;
            end

            stRefreshGap: begin
                busNext.op = opNop;
                if (timerDone) begin
                    refreshLoad = 1'b1;         // rearm interval on idle entry
                    refreshValue = refreshInterval;
                    stateNext = stRefreshIdle;
                end
            end

            default: begin
                busNext.op = opPowerUp;         // unreachable, restart init
                stateNext = stInit;
            end
        endcase
    end

endmodule

//--- src/downTimer.sv
`timescale 1ns/1ps

module downTimer #(
    parameter int width = 16                    // counter width
) (
    input  logic             Clock,
    input  logic             Reset_L,
    input  logic             load,              // one cycle pulse from sequencer
    input  logic [width-1:0] loadValue,         // cycles until done
    output logic             done               // count sits at zero
);

    logic [width-1:0] count;

    ////////////////////////////////////////////////////////////
    // load, count down, hold at zero
    ////////////////////////////////////////////////////////////
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            count <= '0;                        // idle, done high after reset
        end else if (load) begin
            count <= loadValue;                 // load wins over counting
        end else if (count != '0) begin
            count <= count - 1'b1;              // one step per clock
        end
    end

    assign done = (count == '0);                // straight off the register

endmodule

//--- src/sdramController.sv
`timescale 1ns/1ps

module sdramController #(
    parameter logic [sdramSeqPkg::timerWidth-1:0] powerUpCycles = 16'd5000,  // 100 us at 50 MHz
    parameter logic [3:0] initRefreshCount = 4'd8,
    parameter logic [3:0] refreshGap = 4'd3,
    parameter logic [sdramSeqPkg::timerWidth-1:0] refreshInterval = 16'd375, // 7.5 us
    parameter logic [sdramCmdPkg::rowAddrWidth-1:0] modeRegValue = 13'h220   // cl 2, bl 1
) (
    input  logic                   Clock,
    input  logic                   Reset_L,
    output sdramCmdPkg::sdramBus_t sdramBus,
    output logic                   cpuReset_L
);

    import sdramSeqPkg::*;

    logic                  gapLoad;             // power-up and nop gap timing
    logic [timerWidth-1:0] gapValue;
    logic                  gapDone;
    logic                  refLoad;             // refresh interval
    logic [timerWidth-1:0] refValue;
    logic                  refDone;

    ////////////////////////////////////////////////////////////
    // timers
    ////////////////////////////////////////////////////////////
    downTimer #(
        .width     (timerWidth)
    ) gapTimer (
        .Clock     (Clock),
        .Reset_L   (Reset_L),
        .load      (gapLoad),
        .loadValue (gapValue),
        .done      (gapDone)
    );

    downTimer #(
        .width     (timerWidth)
    ) refreshTimer (
        .Clock     (Clock),
        .Reset_L   (Reset_L),
        .load      (refLoad),
        .loadValue (refValue),
        .done      (refDone)
    );

    ////////////////////////////////////////////////////////////
    // init and refresh sequencer
    ////////////////////////////////////////////////////////////
    sdramSequencer #(
        .initRefreshCount (initRefreshCount),
        .refreshGap       (refreshGap),
        .refreshInterval  (refreshInterval),
        .powerUpCycles    (powerUpCycles),
        .modeRegValue     (modeRegValue)
    ) sequencer (
        .Clock            (Clock),
        .Reset_L          (Reset_L),
        .timerDone        (gapDone),
        .refreshDone      (refDone),
        .timerLoad        (gapLoad),
        .timerValue       (gapValue),
        .refreshLoad      (refLoad),
        .refreshValue     (refValue),
        .sdramBus         (sdramBus),
        .cpuReset_L       (cpuReset_L)
    );

endmodule

//--- tests/sdramMonitor.sv
`timescale 1ns/1ps

module sdramMonitor #(
    parameter int powerUpCycles = 8,
    parameter int initRefreshCount = 8,
    parameter int refreshGap = 3,
    parameter int refreshInterval = 60,
    parameter int modeRegValue = 'h220
) (
    input logic                   Clock,
    input logic                   Reset_L,
    input sdramCmdPkg::sdramBus_t sdramBus,
    input logic                   cpuReset_L
);

    import sdramCmdPkg::*;

    typedef enum int {phPower, phPrecharge, phInitGap, phModeGap, phRefresh} phase_t;

    // cke and cs low with address and bank at zero
    localparam sdramBus_t powerUpPins = '{
        op:   opPowerUp,
        addr: '0,
        ba:   '0
    };

    phase_t     phase = phPower;                // where the pins should be in the sequence
    int         checkCount [8] = '{default: 0}; // indexed by behavior number 1 to 6
    int         errorCount [8] = '{default: 0};
    int         resetIdleFails = 0;             // failures of the property checks
    int         cpuFallFails = 0;
    int         refreshCount = 0;               // periodic refreshes since last reset
    int         cycle = 0;
    int         lastRefresh = -1;               // cycle of previous periodic refresh
    int         run = 0;                        // power-up cycles or nops in this phase
    int         groups = 0;                     // init refreshes seen
    logic [4:0] op;
    logic [4:0] prevOp = '0;                    // op one cycle back
    logic [4:0] olderOp = '0;                   // op two cycles back
    logic       prevA10 = 1'b0;
    logic       olderA10 = 1'b0;

    task automatic compareValue(input logic [2:0] beh, input string name,
                                input logic [31:0] expected, input logic [31:0] actual);
        checkCount[beh]++;
        assert (expected === actual) else begin
            errorCount[beh]++;
            $display("MISMATCH %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic verifyCondition(input logic [2:0] beh, input bit ok, input string what);
        checkCount[beh]++;
        assert (ok) else begin
            errorCount[beh]++;
            $display("ERROR %s at %0t", what, $time);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // property checks on reset and cpu reset
    ////////////////////////////////////////////////////////////
    resetIdle: assert property (@(posedge Clock)
        !Reset_L |-> (sdramBus == powerUpPins) && !cpuReset_L) else begin
        resetIdleFails++;
        $display("ERROR pins not idle while Reset_L is low at %0t", $time);
    end

    cpuHeld: assert property (@(posedge Clock) disable iff (!Reset_L)
        $past(cpuReset_L) |-> cpuReset_L) else begin
        cpuFallFails++;
        $display("ERROR cpuReset_L fell while Reset_L stayed high at %0t", $time);
    end

    ////////////////////////////////////////////////////////////
    // sequence model on pins sampled before the edge updates them
    ////////////////////////////////////////////////////////////
    always @(posedge Clock) begin
        cycle++;
        op = sdramBus.op;
        if (!Reset_L) begin
            compareValue(3'd1, "sdramBus", 32'(powerUpPins), 32'(sdramBus));
            compareValue(3'd1, "cpuReset_L", 32'd0, 32'(cpuReset_L));
            if (phase == phRefresh) begin   // reset hit the refresh loop
                compareValue(3'd6, "sdramBus", 32'(powerUpPins), 32'(sdramBus));
                compareValue(3'd6, "cpuReset_L", 32'd0, 32'(cpuReset_L));
            end
            phase = phPower;
            run = 0;
            refreshCount = 0;
            lastRefresh = -1;
        end else begin
            if (phase != phPower) begin
                verifyCondition(3'd5, (op inside {opPowerUp, opDeselect, opNop, opPrecharge,
                                opRefresh, opModeSet}) && op != opDeselect,
                                $sformatf("illegal opcode 0x%0h on the pins", op));
            end
            if (phase == phPrecharge || phase == phInitGap) begin
                compareValue(3'd3, "cpuReset_L", 32'd0, 32'(cpuReset_L));
            end
            case (phase)
                phPower: begin
                    if (op == opPowerUp) begin
                        compareValue(3'd1, "sdramBus", 32'(powerUpPins), 32'(sdramBus));
                        compareValue(3'd1, "cpuReset_L", 32'd0, 32'(cpuReset_L));
                        run++;
                    end else begin
                        verifyCondition(3'd1, run >= powerUpCycles,
                                        $sformatf("power-up wait lasted only %0d cycles", run));
                        compareValue(3'd2, "sdramBus.op", 32'(opNop), 32'(op));
                        compareValue(3'd3, "cpuReset_L", 32'd0, 32'(cpuReset_L));
                        phase = phPrecharge;
                    end
                end
                phPrecharge: begin
                    compareValue(3'd2, "sdramBus.op", 32'(opPrecharge), 32'(op));
                    compareValue(3'd2, "sdramBus.addr", 32'h400, 32'(sdramBus.addr));
                    groups = 0;
                    run = refreshGap;           // first refresh follows at once
                    phase = phInitGap;
                end
                phInitGap: begin
                    if (op == opNop) begin
                        run++;
                        verifyCondition(3'd2, run <= refreshGap, "too many NOPs in init gap");
                    end else begin
                        compareValue(3'd2, "init NOP count", 32'(refreshGap), 32'(run));
                        run = 0;
                        if (groups < initRefreshCount) begin
                            compareValue(3'd2, "sdramBus.op", 32'(opRefresh), 32'(op));
                            groups++;
                        end else begin          // mode set is due once the loop is over
                            compareValue(3'd2, "sdramBus.op", 32'(opModeSet), 32'(op));
                            compareValue(3'd2, "sdramBus.addr", 32'(modeRegValue),
                                         32'(sdramBus.addr));
                            compareValue(3'd2, "sdramBus.ba", 32'd0, 32'(sdramBus.ba));
                            compareValue(3'd3, "cpuReset_L", 32'd0, 32'(cpuReset_L));
                            phase = phModeGap;
                        end
                    end
                end
                phModeGap: begin
                    compareValue(3'd2, "sdramBus.op", 32'(opNop), 32'(op));
                    run++;
                    // cpu reset lifts together with the final nop
                    compareValue(3'd3, "cpuReset_L", 32'(run >= refreshGap), 32'(cpuReset_L));
                    if (run >= refreshGap) begin
                        phase = phRefresh;
                    end
                end
                default: begin
                    compareValue(3'd3, "cpuReset_L", 32'd1, 32'(cpuReset_L));
                    if (op == opRefresh) begin
                        compareValue(3'd4, "sdramBus.op before refresh", 32'(opNop),
                                     32'(prevOp));
                        compareValue(3'd4, "sdramBus.op before NOP", 32'(opPrecharge),
                                     32'(olderOp));
                        compareValue(3'd4, "sdramBus.addr[10] on precharge", 32'd1,
                                     32'(olderA10));
                        if (lastRefresh >= 0) begin
                            verifyCondition(3'd4,
                                cycle - lastRefresh >= refreshInterval + refreshGap + 3 &&
                                cycle - lastRefresh <= refreshInterval + refreshGap + 5,
                                $sformatf("refresh spacing of %0d cycles out of window",
                                          cycle - lastRefresh));
                        end
                        lastRefresh = cycle;
                        refreshCount++;
                    end
                end
            endcase
        end
        olderOp = prevOp;
        olderA10 = prevA10;
        prevOp = op;
        prevA10 = sdramBus.addr[prechargeAllBit];
    end

endmodule

//--- tests/tbSdramController.sv
`timescale 1ns/1ps

module tbSdramController;

    import sdramCmdPkg::*;

    localparam int powerUpCycles = 8;
    localparam int initRefreshCount = 8;
    localparam int refreshGap = 3;
    localparam int refreshInterval = 60;
    localparam int modeRegValue = 'h220;
    localparam logic [31:0] seed = 32'd91705;
    localparam int initLength = powerUpCycles + 2 + initRefreshCount * (refreshGap + 1)
                                + refreshGap + 1;
    localparam int refreshPeriod = refreshInterval + refreshGap + 5;
    localparam int timeoutCycles = 2 * (initLength + 7 * refreshPeriod);

    logic        Clock = 1'b0;
    logic        Reset_L;
    sdramBus_t   sdramBus;
    logic        cpuReset_L;
    int          cycles = 0;
    logic [31:0] rnd;
    int          delay;
    string       names [8] = '{"", "power-up hold", "init order", "cpu reset release",
                               "refresh shape and spacing", "legal opcodes",
                               "reset mid-refresh", ""};

    sdramController #(
        .powerUpCycles    (16'(powerUpCycles)),
        .initRefreshCount (4'(initRefreshCount)),
        .refreshGap       (4'(refreshGap)),
        .refreshInterval  (16'(refreshInterval)),
        .modeRegValue     (13'(modeRegValue))
    ) uut (
        .Clock            (Clock),
        .Reset_L          (Reset_L),
        .sdramBus         (sdramBus),
        .cpuReset_L       (cpuReset_L)
    );

    sdramMonitor #(
        .powerUpCycles    (powerUpCycles),
        .initRefreshCount (initRefreshCount),
        .refreshGap       (refreshGap),
        .refreshInterval  (refreshInterval),
        .modeRegValue     (modeRegValue)
    ) monitor (
        .Clock            (Clock),
        .Reset_L          (Reset_L),
        .sdramBus         (sdramBus),
        .cpuReset_L       (cpuReset_L)
    );

    always #10 Clock = ~Clock;                  // 50 MHz

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic applyReset();
        Reset_L = 1'b0;
        repeat (4) @(negedge Clock);            // four full cycles low
        Reset_L = 1'b1;
    endtask

    task automatic awaitRefreshes(input int target);
        while (monitor.refreshCount < target) @(negedge Clock);
    endtask

    task automatic printReport();
        int         checks;
        int         errs;
        int         totalChecks;
        int         totalErrors;
        bit         failed;
        logic [2:0] idx;
        totalChecks = 0;
        totalErrors = 0;
        failed = 1'b0;
        for (idx = 3'd1; idx != 3'd7; idx++) begin
            checks = monitor.checkCount[idx];
            errs = monitor.errorCount[idx];
            if (idx == 3'd1) errs += monitor.resetIdleFails;
            if (idx == 3'd3) errs += monitor.cpuFallFails;
            if (checks == 0) begin
                $display("behavior %0d %s: FAIL, never exercised", idx, names[idx]);
                failed = 1'b1;
            end else if (errs != 0) begin
                $display("behavior %0d %s: FAIL, %0d of %0d checks failed", idx, names[idx],
                         errs, checks);
            end else begin
                $display("behavior %0d %s: PASS, %0d checks", idx, names[idx], checks);
            end
            totalChecks += checks;
            totalErrors += errs;
        end
        $display("total checks: %0d, errors: %0d", totalChecks, totalErrors);
        if (failed || totalErrors != 0) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus, reset is the only input
    ////////////////////////////////////////////////////////////
    initial begin
        Reset_L = 1'b0;
        applyReset();
        awaitRefreshes(5);                      // power-on run
        rnd = xorshift32(seed);
        delay = int'(rnd % 32'(refreshInterval)) + 1;
        repeat (delay) @(negedge Clock);        // still inside the refresh loop
        applyReset();
        awaitRefreshes(2);                      // second init and two refreshes
        repeat (4) @(negedge Clock);
        printReport();
    end

    always @(posedge Clock) begin
        cycles++;
        if (cycles >= timeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

//--- verilog.f
common/sdramCmdPkg.sv
common/sdramSeqPkg.sv
src/downTimer.sv
sequencer/sdramSequencer.sv
src/sdramController.sv
tests/sdramMonitor.sv
tests/tbSdramController.sv
